// ==== Bender.yml ====
package:
  name: dma_ctrl

sources:
  - dma_pkg.sv
  - dma_axi_ingress.sv
  - dma_cmd_buffer.sv
  - dma_mem_issue.sv
  - dma_axi_response.sv
  - dma_ctrl.sv
  - target: simulation
    files:
      - tb_dma_ctrl.sv

// ==== dma_axi_ingress.sv ====
// Single-beat AXI only; burst fields are not present and writes need both AW and W held
`timescale 1ns/1ps

module dma_axi_ingress import dma_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [DMA_TAG_W-1:0]  awid,
   input  logic [DMA_ADDR_W-1:0] awaddr,
   input  logic [2:0]            awsize,
   input  logic                  wvalid,
   output logic                  wready,
   input  logic [DMA_DATA_W-1:0] wdata,
   input  logic [DMA_STRB_W-1:0] wstrb,
   input  logic                  arvalid,
   output logic                  arready,
   input  logic [DMA_TAG_W-1:0]  arid,
   input  logic [DMA_ADDR_W-1:0] araddr,
   input  logic [2:0]            arsize,
   input  logic                  cmd_ready,
   output logic                  cmd_sent,
   output logic                  cmd_write,
   output logic [DMA_ADDR_W-1:0] cmd_addr,
   output logic [2:0]            cmd_sz,
   output logic [DMA_DATA_W-1:0] cmd_wdata,
   output logic [DMA_STRB_W-1:0] cmd_byteen,
   output logic [DMA_TAG_W-1:0]  cmd_tag,
   output logic                  ingress_busy
);

   logic                  aw_vld, w_vld, ar_vld;
   logic [DMA_TAG_W-1:0]  aw_id, ar_id;
   logic [DMA_ADDR_W-1:0] aw_addr, ar_addr;
   logic [2:0]            aw_sz, ar_sz;
   logic [DMA_DATA_W-1:0] w_data;
   logic [DMA_STRB_W-1:0] w_strb;
   logic                  wr_avail;     // AW and W both held
   logic                  wr_prio;      // 1 gives the write the next tie
   logic                  wr_sent, rd_sent;

   // **************************************************************************
   // Command select
   // **************************************************************************
   assign wr_avail   = aw_vld & w_vld;
   assign cmd_write  = (wr_avail & ar_vld) ? wr_prio : wr_avail;
   assign cmd_sent   = (wr_avail | ar_vld) & cmd_ready;
   assign wr_sent    = cmd_sent & cmd_write;
   assign rd_sent    = cmd_sent & ~cmd_write;

   assign cmd_addr   = cmd_write ? aw_addr : ar_addr;
   assign cmd_sz     = cmd_write ? aw_sz : ar_sz;
   assign cmd_tag    = cmd_write ? aw_id : ar_id;
   assign cmd_wdata  = w_data;
   assign cmd_byteen = w_strb;

   // A register frees in the cycle its command leaves
   assign awready = ~aw_vld | wr_sent;
   assign wready  = ~w_vld | wr_sent;
   assign arready = ~ar_vld | rd_sent;

   assign ingress_busy = aw_vld | w_vld | ar_vld;

   always_ff @(posedge clk) begin
      if (reset) begin
         aw_vld  <= 1'b0;
         w_vld   <= 1'b0;
         ar_vld  <= 1'b0;
         wr_prio <= 1'b0;                  // Read wins first
      end else begin
         if (awvalid && awready) aw_vld <= 1'b1;
         else if (wr_sent)       aw_vld <= 1'b0;
         if (wvalid && wready)   w_vld  <= 1'b1;
         else if (wr_sent)       w_vld  <= 1'b0;
         if (arvalid && arready) ar_vld <= 1'b1;
         else if (rd_sent)       ar_vld <= 1'b0;
         if (cmd_sent)           wr_prio <= ~wr_prio;
      end
   end

   // Holding register payload
   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         aw_id   <= awid;
         aw_addr <= awaddr;
         aw_sz   <= awsize;
      end
      if (wvalid && wready) begin
         w_data <= wdata;
         w_strb <= wstrb;
      end
      if (arvalid && arready) begin
         ar_id   <= arid;
         ar_addr <= araddr;
         ar_sz   <= arsize;
      end
   end

endmodule

// ==== dma_axi_response.sv ====
// One response outstanding at a time; rlast is always set since reads are single beat
`timescale 1ns/1ps

module dma_axi_response import dma_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  rsp_ready,
   input  logic                  rsp_write,
   input  dma_err_e              rsp_err,
   input  logic [DMA_DATA_W-1:0] rsp_data,
   input  logic [DMA_TAG_W-1:0]  rsp_tag,
   output logic [DMA_PTR_W-1:0]  rsp_ptr,
   output logic                  rsp_pop,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [DMA_TAG_W-1:0]  bid,
   output logic [1:0]            bresp,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [DMA_TAG_W-1:0]  rid,
   output logic [DMA_DATA_W-1:0] rdata,
   output logic [1:0]            rresp,
   output logic                  rlast
);

   axi_resp_e rsp_code;

   always_comb begin
      case (rsp_err)
         ERR_SLAVE:  rsp_code = RESP_SLVERR;
         ERR_DECODE: rsp_code = RESP_DECERR;
         default:    rsp_code = RESP_OKAY;
      endcase
   end

   assign bvalid = rsp_ready & rsp_write;
   assign bid    = rsp_tag;
   assign bresp  = rsp_code;
   assign rvalid = rsp_ready & ~rsp_write;
   assign rid    = rsp_tag;
   assign rdata  = rsp_data;
   assign rresp  = rsp_code;
   assign rlast  = 1'b1;

   assign rsp_pop = (bvalid & bready) | (rvalid & rready);

   always_ff @(posedge clk) begin
      if (reset)        rsp_ptr <= '0;
      else if (rsp_pop) rsp_ptr <= rsp_ptr + 1'b1;  // Next entry in command order
   end

endmodule

// ==== dma_cmd_buffer.sv ====
// Entries are issued and answered strictly in order; full flag lags rsp_pop by one cycle
`timescale 1ns/1ps

module dma_cmd_buffer import dma_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  cmd_sent,
   input  logic                  cmd_write,
   input  logic [DMA_ADDR_W-1:0] cmd_addr,
   input  logic [2:0]            cmd_sz,
   input  logic [DMA_DATA_W-1:0] cmd_wdata,
   input  logic [DMA_STRB_W-1:0] cmd_byteen,
   input  logic [DMA_TAG_W-1:0]  cmd_tag,
   input  logic                  ingress_busy,
   output logic                  cmd_ready,
   output logic                  head_valid,
   output logic [DMA_ADDR_W-1:0] head_addr,
   output logic [2:0]            head_sz,
   output logic                  head_write,
   output logic [DMA_STRB_W-1:0] head_byteen,
   output logic [DMA_DATA_W-1:0] head_wdata,
   output logic [DMA_PTR_W-1:0]  head_tag,
   input  logic                  head_issued,
   input  logic                  head_fail,
   input  dma_err_e              head_err,
   input  logic                  dccm_rvalid,
   input  logic [DMA_PTR_W-1:0]  dccm_rtag,
   input  logic                  dccm_ecc_error,
   input  logic [DMA_DATA_W-1:0] dccm_rdata,
   input  logic                  iccm_rvalid,
   input  logic [DMA_PTR_W-1:0]  iccm_rtag,
   input  logic                  iccm_ecc_error,
   input  logic [DMA_DATA_W-1:0] iccm_rdata,
   input  logic [DMA_PTR_W-1:0]  rsp_ptr,
   input  logic                  rsp_pop,
   output logic                  rsp_ready,
   output logic                  rsp_write,
   output dma_err_e              rsp_err,
   output logic [DMA_DATA_W-1:0] rsp_data,
   output logic [DMA_TAG_W-1:0]  rsp_tag,
   output logic                  dma_active
);

   logic [DMA_DEPTH-1:0]                 ent_valid, ent_pend, ent_done;
   dma_err_e                             ent_err [DMA_DEPTH];
   logic [DMA_DEPTH-1:0][DMA_ADDR_W-1:0] ent_addr;
   logic [DMA_DEPTH-1:0][2:0]            ent_sz;
   logic [DMA_DEPTH-1:0][DMA_STRB_W-1:0] ent_byteen;
   logic [DMA_DEPTH-1:0]                 ent_write;
   logic [DMA_DEPTH-1:0][DMA_DATA_W-1:0] ent_data;
   logic [DMA_DEPTH-1:0][DMA_TAG_W-1:0]  ent_tag;

   logic [DMA_PTR_W-1:0] wr_ptr, rd_ptr;
   logic [DMA_DEPTH-1:0] wr_hit, rd_hit, rsp_hit, dccm_hit, iccm_hit;
   logic [DMA_PTR_W+1:0] num_vld;           // Valid entries next cycle, worst case
   logic                 full;

   always_comb begin
      for (int i = 0; i < DMA_DEPTH; i++) begin
         wr_hit[i]   = cmd_sent && (wr_ptr == DMA_PTR_W'(i));
         rd_hit[i]   = rd_ptr == DMA_PTR_W'(i);
         rsp_hit[i]  = rsp_pop && (rsp_ptr == DMA_PTR_W'(i));
         dccm_hit[i] = dccm_rvalid && (dccm_rtag == DMA_PTR_W'(i));
         iccm_hit[i] = iccm_rvalid && (iccm_rtag == DMA_PTR_W'(i));
      end
   end

   always_comb begin
      num_vld = (DMA_PTR_W+2)'(cmd_sent);
      for (int i = 0; i < DMA_DEPTH; i++) num_vld = num_vld + (DMA_PTR_W+2)'(ent_valid[i]);
      num_vld = num_vld - (DMA_PTR_W+2)'(rsp_pop);
   end

   // **************************************************************************
   // Entry state and pointers
   // **************************************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         ent_valid <= '0;
         ent_pend  <= '0;
         ent_done  <= '0;
         for (int i = 0; i < DMA_DEPTH; i++) ent_err[i] <= ERR_NONE;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         full      <= 1'b0;
      end else begin
         for (int i = 0; i < DMA_DEPTH; i++) begin
            if (rsp_hit[i]) begin           // Answered on B or R
               ent_valid[i] <= 1'b0;
               ent_pend[i]  <= 1'b0;
               ent_done[i]  <= 1'b0;
               ent_err[i]   <= ERR_NONE;
            end else begin
               if (wr_hit[i]) ent_valid[i] <= 1'b1;
               if (rd_hit[i] && head_issued) begin
                  if (ent_write[i]) ent_done[i] <= 1'b1;
                  else              ent_pend[i] <= 1'b1;
               end
               if (rd_hit[i] && head_fail) begin
                  ent_done[i] <= 1'b1;
                  ent_err[i]  <= head_err;
               end
               if (dccm_hit[i] || iccm_hit[i]) ent_done[i] <= 1'b1;
               if ((dccm_hit[i] && dccm_ecc_error) || (iccm_hit[i] && iccm_ecc_error))
                  ent_err[i] <= ERR_SLAVE;
            end
         end
         if (cmd_sent) wr_ptr <= wr_ptr + 1'b1;
         if (head_issued || head_fail) rd_ptr <= rd_ptr + 1'b1;
         full <= num_vld >= (DMA_PTR_W+2)'(DMA_DEPTH);
      end
   end

   // Entry payload
   always_ff @(posedge clk) begin
      for (int i = 0; i < DMA_DEPTH; i++) begin
         if (wr_hit[i]) begin
            ent_addr[i]   <= cmd_addr;
            ent_sz[i]     <= cmd_sz;
            ent_byteen[i] <= cmd_byteen;
            ent_write[i]  <= cmd_write;
            ent_tag[i]    <= cmd_tag;
         end
         if (wr_hit[i] && cmd_write) ent_data[i] <= cmd_wdata;
         else if (rd_hit[i] && head_fail && !ent_write[i])
            ent_data[i] <= DMA_DATA_W'(ent_addr[i]);    // Failing address goes back as data
         else if (dccm_hit[i]) ent_data[i] <= dccm_rdata;
         else if (iccm_hit[i]) ent_data[i] <= iccm_rdata;
      end
   end

   assign cmd_ready   = ~full;
   assign head_valid  = ent_valid[rd_ptr] & ~ent_pend[rd_ptr] & ~ent_done[rd_ptr];
   assign head_addr   = ent_addr[rd_ptr];
   assign head_sz     = ent_sz[rd_ptr];
   assign head_write  = ent_write[rd_ptr];
   assign head_byteen = ent_byteen[rd_ptr];
   assign head_wdata  = ent_data[rd_ptr];
   assign head_tag    = rd_ptr;

   assign rsp_ready  = ent_valid[rsp_ptr] & ent_done[rsp_ptr];
   assign rsp_write  = ent_write[rsp_ptr];
   assign rsp_err    = ent_err[rsp_ptr];
   assign rsp_data   = ent_data[rsp_ptr];
   assign rsp_tag    = ent_tag[rsp_ptr];
   assign dma_active = (|ent_valid) | ingress_busy;

endmodule

// ==== dma_ctrl.sv ====
// DMA slave for DCCM/ICCM; single clock, no debug port, no PIC window
`timescale 1ns/1ps

module dma_ctrl import dma_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   // AXI write
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [DMA_TAG_W-1:0]  awid,
   input  logic [DMA_ADDR_W-1:0] awaddr,
   input  logic [2:0]            awsize,
   input  logic                  wvalid,
   output logic                  wready,
   input  logic [DMA_DATA_W-1:0] wdata,
   input  logic [DMA_STRB_W-1:0] wstrb,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [DMA_TAG_W-1:0]  bid,
   output logic [1:0]            bresp,
   // AXI read
   input  logic                  arvalid,
   output logic                  arready,
   input  logic [DMA_TAG_W-1:0]  arid,
   input  logic [DMA_ADDR_W-1:0] araddr,
   input  logic [2:0]            arsize,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [DMA_TAG_W-1:0]  rid,
   output logic [DMA_DATA_W-1:0] rdata,
   output logic [1:0]            rresp,
   output logic                  rlast,
   // Core memories
   output logic                  dma_dccm_req,
   output logic                  dma_iccm_req,
   output logic [DMA_PTR_W-1:0]  dma_mem_tag,
   output logic [DMA_ADDR_W-1:0] dma_mem_addr,
   output logic [2:0]            dma_mem_sz,
   output logic                  dma_mem_write,
   output logic [DMA_DATA_W-1:0] dma_mem_wdata,
   input  logic                  dccm_ready,
   input  logic                  iccm_ready,
   input  logic                  dccm_rvalid,
   input  logic [DMA_PTR_W-1:0]  dccm_rtag,
   input  logic                  dccm_ecc_error,
   input  logic [DMA_DATA_W-1:0] dccm_rdata,
   input  logic                  iccm_rvalid,
   input  logic [DMA_PTR_W-1:0]  iccm_rtag,
   input  logic                  iccm_ecc_error,
   input  logic [DMA_DATA_W-1:0] iccm_rdata,
   output logic                  dma_active
);

   // Ingress to buffer
   logic                  cmd_sent, cmd_write, cmd_ready, ingress_busy;
   logic [DMA_ADDR_W-1:0] cmd_addr;
   logic [2:0]            cmd_sz;
   logic [DMA_DATA_W-1:0] cmd_wdata;
   logic [DMA_STRB_W-1:0] cmd_byteen;
   logic [DMA_TAG_W-1:0]  cmd_tag;

   // Buffer head to issue
   logic                  head_valid, head_write, head_issued, head_fail;
   logic [DMA_ADDR_W-1:0] head_addr;
   logic [2:0]            head_sz;
   logic [DMA_STRB_W-1:0] head_byteen;
   logic [DMA_DATA_W-1:0] head_wdata;
   logic [DMA_PTR_W-1:0]  head_tag;
   dma_err_e              head_err;

   // Buffer to response
   logic [DMA_PTR_W-1:0]  rsp_ptr;
   logic                  rsp_pop, rsp_ready, rsp_write;
   dma_err_e              rsp_err;
   logic [DMA_DATA_W-1:0] rsp_data;
   logic [DMA_TAG_W-1:0]  rsp_tag;

   dma_axi_ingress  u_ingress  (.*);
   dma_cmd_buffer   u_buffer   (.*);
   dma_mem_issue    u_issue    (.*);
   dma_axi_response u_response (.*);

endmodule

// ==== dma_mem_issue.sv ====
// Checks only the head entry; a target that is not ready stalls everything behind it
`timescale 1ns/1ps

module dma_mem_issue import dma_pkg::*; (
   input  logic                  head_valid,
   input  logic [DMA_ADDR_W-1:0] head_addr,
   input  logic [2:0]            head_sz,
   input  logic                  head_write,
   input  logic [DMA_STRB_W-1:0] head_byteen,
   input  logic [DMA_DATA_W-1:0] head_wdata,
   input  logic [DMA_PTR_W-1:0]  head_tag,
   input  logic                  dccm_ready,
   input  logic                  iccm_ready,
   output logic                  head_issued,
   output logic                  head_fail,
   output dma_err_e              head_err,
   output logic                  dma_dccm_req,
   output logic                  dma_iccm_req,
   output logic [DMA_PTR_W-1:0]  dma_mem_tag,
   output logic [DMA_ADDR_W-1:0] dma_mem_addr,
   output logic [2:0]            dma_mem_sz,
   output logic                  dma_mem_write,
   output logic [DMA_DATA_W-1:0] dma_mem_wdata
);

   logic in_dccm, in_iccm, in_range;
   logic misalign, word_or_dword, size_bad;
   logic word_strb_bad, dword_strb_bad;
   logic strb_lo, strb_hi;                  // Writes with a half-dword strobe
   logic slave_err, req_ok;

   // **************************************************************************
   // Range and alignment checks
   // **************************************************************************
   assign in_dccm  = (head_addr - DCCM_BASE) < DCCM_SIZE;
   assign in_iccm  = (head_addr - ICCM_BASE) < ICCM_SIZE;
   assign in_range = in_dccm | in_iccm;

   assign misalign = ((head_sz == SZ_HALF)  & head_addr[0])        |
                     ((head_sz == SZ_WORD)  & (|head_addr[1:0]))   |
                     ((head_sz == SZ_DWORD) & (|head_addr[2:0]));

   assign word_or_dword = (head_sz == SZ_WORD) | (head_sz == SZ_DWORD);
   assign size_bad      = (in_iccm | (in_dccm & head_write)) & ~word_or_dword;

   // Word store needs its four lanes set
   assign word_strb_bad = head_write & (head_sz == SZ_WORD) &
                          ((head_addr[2] ? head_byteen[7:4] : head_byteen[3:0]) != 4'hF);

   assign strb_lo        = head_write & (head_byteen == 8'h0F);
   assign strb_hi        = head_write & (head_byteen == 8'hF0);
   assign dword_strb_bad = head_write & (head_sz == SZ_DWORD) &
                           ~(strb_lo | strb_hi | (head_byteen == 8'hFF));

   assign slave_err = misalign | size_bad | word_strb_bad | dword_strb_bad;

   assign head_fail = head_valid & (~in_range | slave_err);
   assign head_err  = ~head_fail ? ERR_NONE   :
                      ~in_range  ? ERR_DECODE : ERR_SLAVE;

   // **************************************************************************
   // Memory request
   // **************************************************************************
   assign req_ok       = head_valid & in_range & ~slave_err;
   assign dma_dccm_req = req_ok & in_dccm & dccm_ready;
   assign dma_iccm_req = req_ok & in_iccm & iccm_ready;
   assign head_issued  = dma_dccm_req | dma_iccm_req;

   // Half-dword writes become a word access to the lane holding the data
   assign dma_mem_sz    = (strb_lo | strb_hi) ? SZ_WORD : head_sz;
   assign dma_mem_addr  = strb_hi ? {head_addr[31:3], 1'b1, head_addr[1:0]} : head_addr;
   assign dma_mem_tag   = head_tag;
   assign dma_mem_write = head_write;
   assign dma_mem_wdata = head_wdata;

endmodule

// ==== dma_pkg.sv ====
// Shared widths, memory map and encodings; both CCM windows must be 64 KiB aligned
package dma_pkg;

   // **************************************************************************
   // Buffer and bus widths
   // **************************************************************************
   localparam int DMA_DEPTH  = 4;   // Command buffer entries
   localparam int DMA_PTR_W  = 2;   // Entry pointer, also the memory tag
   localparam int DMA_TAG_W  = 1;   // AXI id
   localparam int DMA_ADDR_W = 32;
   localparam int DMA_DATA_W = 64;
   localparam int DMA_STRB_W = 8;

   // **************************************************************************
   // Memory map
   // **************************************************************************
   localparam logic [DMA_ADDR_W-1:0] DCCM_BASE = 32'hF004_0000;
   localparam logic [DMA_ADDR_W-1:0] DCCM_SIZE = 32'h0001_0000;
   localparam logic [DMA_ADDR_W-1:0] ICCM_BASE = 32'hEE00_0000;
   localparam logic [DMA_ADDR_W-1:0] ICCM_SIZE = 32'h0001_0000;

   // AXI size encodings
   typedef enum logic [2:0] {
      SZ_BYTE  = 3'd0,
      SZ_HALF  = 3'd1,
      SZ_WORD  = 3'd2,
      SZ_DWORD = 3'd3
   } dma_size_e;

   // Error held per entry
   typedef enum logic [1:0] {
      ERR_NONE   = 2'd0,
      ERR_SLAVE  = 2'd1,   // Alignment or read ECC
      ERR_DECODE = 2'd2    // Outside DCCM and ICCM
   } dma_err_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2,
      RESP_DECERR = 2'd3
   } axi_resp_e;

endpackage

// ==== sim.f ====
dma_pkg.sv
dma_axi_ingress.sv
dma_cmd_buffer.sv
dma_mem_issue.sv
dma_axi_response.sv
dma_ctrl.sv
tb_dma_ctrl.sv

// ==== tb_dma_ctrl.sv ====
// Back-pressure rows must come in pairs of a write then a read; DCCM ready drops at random
`timescale 1ns/1ps

module tb_dma_ctrl import dma_pkg::*; ();

   localparam int          NUM_ROWS = 33;
   localparam logic [31:0] ECC_ADDR = DCCM_BASE + 32'h1F0;   // Memory model flags ECC here
   localparam logic [31:0] D0       = DCCM_BASE + 32'h100;
   localparam logic [31:0] I0       = ICCM_BASE + 32'h200;

   logic clk = 1'b0;
   logic reset;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready, rlast;
   logic [DMA_TAG_W-1:0]  awid, bid, arid, rid;
   logic [DMA_ADDR_W-1:0] awaddr, araddr, dma_mem_addr;
   logic [2:0]            awsize, arsize, dma_mem_sz;
   logic [DMA_DATA_W-1:0] wdata, rdata, dma_mem_wdata, dccm_rdata, iccm_rdata;
   logic [DMA_STRB_W-1:0] wstrb;
   logic [1:0]            bresp, rresp;
   logic                  dma_dccm_req, dma_iccm_req, dma_mem_write, dma_active;
   logic                  dccm_ready, iccm_ready;
   logic                  dccm_rvalid, dccm_ecc_error, iccm_rvalid, iccm_ecc_error;
   logic [DMA_PTR_W-1:0]  dma_mem_tag, dccm_rtag, iccm_rtag;

   // Stimulus table
   bit                    row_write [NUM_ROWS];
   logic [DMA_TAG_W-1:0]  row_id    [NUM_ROWS];
   logic [DMA_ADDR_W-1:0] row_addr  [NUM_ROWS];
   dma_size_e             row_sz    [NUM_ROWS];
   logic [DMA_DATA_W-1:0] row_wdata [NUM_ROWS];
   logic [DMA_STRB_W-1:0] row_wstrb [NUM_ROWS];
   bit                    row_bp    [NUM_ROWS];   // Hold bready and rready low
   axi_resp_e             row_resp  [NUM_ROWS];
   logic [DMA_DATA_W-1:0] row_rdata [NUM_ROWS];
   int                    row_cnt = 0;

   logic [7:0]  ref_mem   [0:131071];   // Expected bytes, DCCM then ICCM
   logic [63:0] model_mem [0:16383];    // Memory model storage
   integer      seed = 32'h0ba9cb79;

   // Read return pipeline of the memory model
   logic                  p1_vld, p2_vld, p1_iccm, p2_iccm, p1_ecc, p2_ecc;
   logic [DMA_PTR_W-1:0]  p1_tag, p2_tag;
   logic [DMA_DATA_W-1:0] p1_data, p2_data;

   dma_ctrl u_dut (.*);

   always #4 clk = ~clk;

   function automatic logic [63:0] fill_dword(input logic [31:0] a);
      return {a ^ 32'h5A5A_0F0F, ~a};
   endfunction

   function automatic logic [13:0] mem_index(input logic [31:0] a);
      return {a[31:16] == ICCM_BASE[31:16], a[15:3]};
   endfunction

   // **************************************************************************
   // DCCM/ICCM model
   // **************************************************************************
   always @(posedge clk) begin
      if (reset) begin
         p1_vld <= 1'b0;
         p2_vld <= 1'b0;
      end else begin
         p2_vld  <= p1_vld;
         p2_iccm <= p1_iccm;
         p2_ecc  <= p1_ecc;
         p2_tag  <= p1_tag;
         p2_data <= p1_data;
         p1_vld  <= (dma_dccm_req || dma_iccm_req) && !dma_mem_write;
         p1_iccm <= dma_iccm_req;
         p1_ecc  <= dma_dccm_req && (dma_mem_addr[31:3] == ECC_ADDR[31:3]);
         p1_tag  <= dma_mem_tag;
         p1_data <= model_mem[mem_index(dma_mem_addr)];
         if ((dma_dccm_req || dma_iccm_req) && dma_mem_write) begin
            if (dma_mem_sz == SZ_DWORD)
               model_mem[mem_index(dma_mem_addr)] = dma_mem_wdata;
            else if (dma_mem_addr[2])                 // Word into upper lane
               model_mem[mem_index(dma_mem_addr)][63:32] = dma_mem_wdata[63:32];
            else
               model_mem[mem_index(dma_mem_addr)][31:0] = dma_mem_wdata[31:0];
         end
      end
   end

   always @(negedge clk) begin
      dccm_rvalid    = p2_vld & ~p2_iccm;
      iccm_rvalid    = p2_vld & p2_iccm;
      dccm_rtag      = p2_tag;
      iccm_rtag      = p2_tag;
      dccm_rdata     = p2_data;
      iccm_rdata     = p2_data;
      dccm_ecc_error = p2_ecc;
      dccm_ready     = reset | (($random(seed) & 3) != 0);   // Low about one cycle in four
   end

   // **************************************************************************
   // Checks
   // **************************************************************************
   task automatic stop_run();
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e got);
      if (got !== exp) begin
         $display("error %s expected %h got %h", name, exp, got);
         stop_run();
      end
   endtask

   task automatic check_data(input string name, input logic [DMA_DATA_W-1:0] exp,
                             input logic [DMA_DATA_W-1:0] got);
      if (got !== exp) begin
         $display("error %s expected %h got %h", name, exp, got);
         stop_run();
      end
   endtask

   task automatic check_id(input string name, input logic [DMA_TAG_W-1:0] exp,
                           input logic [DMA_TAG_W-1:0] got);
      if (got !== exp) begin
         $display("error %s expected %h got %h", name, exp, got);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         $display("error %s expected %h got %h", name, exp, got);
         stop_run();
      end
   endtask

   // **************************************************************************
   // Table setup
   // **************************************************************************
   task automatic init_memories();
      logic [31:0] a;
      logic [63:0] d;
      for (int k = 0; k < 16384; k++) begin
         a = (k >= 8192) ? ICCM_BASE + 32'((k - 8192) * 8) : DCCM_BASE + 32'(k * 8);
         d = fill_dword(a);
         model_mem[k] = d;
         for (int b = 0; b < 8; b++) ref_mem[k * 8 + b] = d[8 * b +: 8];
      end
   endtask

   task automatic add_row(input bit w, input logic [DMA_TAG_W-1:0] id, input logic [31:0] a,
                          input dma_size_e sz, input logic [63:0] d, input logic [7:0] s,
                          input bit bp, input axi_resp_e resp);
      logic [63:0] cur;
      int          base;
      base = int'(mem_index(a)) * 8;
      for (int b = 0; b < 8; b++) cur[8 * b +: 8] = ref_mem[base + b];
      if (w && resp == RESP_OKAY) begin                 // Merge by strobes
         for (int b = 0; b < 8; b++) begin
            if (s[b]) ref_mem[base + b] = d[8 * b +: 8];
         end
      end
      row_write[row_cnt] = w;
      row_id[row_cnt]    = id;
      row_addr[row_cnt]  = a;
      row_sz[row_cnt]    = sz;
      row_wdata[row_cnt] = d;
      row_wstrb[row_cnt] = s;
      row_bp[row_cnt]    = bp;
      row_resp[row_cnt]  = resp;
      // Rejected reads return their own address
      row_rdata[row_cnt] = (resp == RESP_OKAY || a == ECC_ADDR) ? cur : 64'(a);
      row_cnt++;
   endtask

   task automatic build_table();
      // Mixed strobes on one DCCM dword, then 0xF0 alone
      add_row(1, 0, D0, SZ_DWORD, 64'h1122_3344_5566_7788, 8'hFF, 0, RESP_OKAY);
      add_row(1, 1, D0, SZ_DWORD, 64'hAAAA_BBBB_CCCC_DDDD, 8'h0F, 0, RESP_OKAY);
      add_row(1, 0, D0, SZ_DWORD, 64'h9999_8888_7777_6666, 8'hF0, 0, RESP_OKAY);
      add_row(0, 1, D0, SZ_DWORD, '0, 8'h00, 0, RESP_OKAY);
      add_row(1, 1, D0 + 8, SZ_DWORD, 64'h0123_4567_89AB_CDEF, 8'hF0, 0, RESP_OKAY);
      add_row(0, 0, D0 + 8, SZ_DWORD, '0, 8'h00, 0, RESP_OKAY);
      // ICCM word and dword
      add_row(1, 0, I0, SZ_WORD, 64'hDEAD_BEEF_5A5A_1234, 8'h0F, 0, RESP_OKAY);
      add_row(1, 1, I0 + 8, SZ_DWORD, 64'hFEDC_BA98_7654_3210, 8'hFF, 0, RESP_OKAY);
      add_row(0, 1, I0, SZ_WORD, '0, 8'h00, 0, RESP_OKAY);
      add_row(0, 0, I0 + 8, SZ_DWORD, '0, 8'h00, 0, RESP_OKAY);
      add_row(1, 0, I0 + 4, SZ_WORD, 64'hC0DE_CAFE_0000_0000, 8'hF0, 0, RESP_OKAY);
      add_row(0, 1, I0 + 4, SZ_WORD, '0, 8'h00, 0, RESP_OKAY);
      // Outside both windows
      add_row(0, 0, 32'h1000_0000, SZ_DWORD, '0, 8'h00, 0, RESP_DECERR);
      add_row(1, 1, DCCM_BASE + DCCM_SIZE, SZ_DWORD, 64'h1, 8'hFF, 0, RESP_DECERR);
      // Alignment, size and strobe faults, then the ECC address
      add_row(0, 0, D0 + 1, SZ_HALF, '0, 8'h00, 0, RESP_SLVERR);
      add_row(0, 1, I0, SZ_BYTE, '0, 8'h00, 0, RESP_SLVERR);
      add_row(1, 0, D0 + 16, SZ_BYTE, 64'hFF, 8'h01, 0, RESP_SLVERR);
      add_row(1, 1, D0 + 16, SZ_DWORD, 64'h3C3C_3C3C_3C3C_3C3C, 8'h3C, 0, RESP_SLVERR);
      add_row(0, 0, ECC_ADDR, SZ_DWORD, '0, 8'h00, 0, RESP_SLVERR);
      add_row(1, 1, D0 + 20, SZ_WORD, 64'h5555_6666_0000_0000, 8'hF0, 0, RESP_OKAY);
      // Held responses, each pair a write then a read
      add_row(1, 0, D0 + 24, SZ_DWORD, 64'h2468_ACE0_1357_9BDF, 8'hFF, 1, RESP_OKAY);
      add_row(0, 1, D0, SZ_DWORD, '0, 8'h00, 1, RESP_OKAY);
      add_row(1, 1, I0 + 16, SZ_DWORD, 64'h7777_0000_3333_1111, 8'hFF, 1, RESP_OKAY);
      add_row(0, 0, D0 + 24, SZ_DWORD, '0, 8'h00, 1, RESP_OKAY);
      add_row(1, 0, D0 + 16, SZ_DWORD, 64'hABCD_0000_1234_FFFF, 8'h0F, 1, RESP_OKAY);
      add_row(0, 1, I0 + 16, SZ_DWORD, '0, 8'h00, 1, RESP_OKAY);
      // Both word lanes of D0 + 16 written separately
      add_row(0, 0, D0 + 16, SZ_DWORD, '0, 8'h00, 0, RESP_OKAY);
      // Odd command count here, so the write wins each tie
      add_row(1, 1, D0 + 32, SZ_DWORD, 64'h0F1E_2D3C_4B5A_6978, 8'hFF, 1, RESP_OKAY);
      add_row(0, 0, I0 + 8, SZ_DWORD, '0, 8'h00, 1, RESP_OKAY);
      add_row(1, 0, I0 + 24, SZ_DWORD, 64'h8765_4321_0FED_CBA9, 8'hF0, 1, RESP_OKAY);
      add_row(0, 1, D0 + 32, SZ_DWORD, '0, 8'h00, 1, RESP_OKAY);
      add_row(1, 1, D0 + 40, SZ_WORD, 64'h0000_0000_BEEF_F00D, 8'h0F, 1, RESP_OKAY);
      add_row(0, 0, I0 + 24, SZ_DWORD, '0, 8'h00, 1, RESP_OKAY);
   endtask

   // **************************************************************************
   // AXI drive and response collection
   // **************************************************************************
   task automatic present_cmds(input bit do_wr, input int wi, input bit do_rd, input int ri);
      bit aw_wait, w_wait, ar_wait;
      aw_wait = do_wr;
      w_wait  = do_wr;
      ar_wait = do_rd;
      @(negedge clk);
      if (do_wr) begin
         awvalid = 1'b1;
         awid    = row_id[wi];
         awaddr  = row_addr[wi];
         awsize  = row_sz[wi];
         wvalid  = 1'b1;
         wdata   = row_wdata[wi];
         wstrb   = row_wstrb[wi];
      end
      if (do_rd) begin
         arvalid = 1'b1;
         arid    = row_id[ri];
         araddr  = row_addr[ri];
         arsize  = row_sz[ri];
      end
      while (aw_wait || w_wait || ar_wait) begin
         @(posedge clk);
         if (awvalid && awready) aw_wait = 1'b0;
         if (wvalid && wready)   w_wait  = 1'b0;
         if (arvalid && arready) ar_wait = 1'b0;
         @(negedge clk);
         awvalid = aw_wait;
         wvalid  = w_wait;
         arvalid = ar_wait;
      end
   endtask

   task automatic collect_resp(input int i);
      @(posedge clk);
      while (!(bvalid || rvalid)) @(posedge clk);
      if (row_write[i]) begin
         check_flag("bvalid", 1'b1, bvalid);
         check_id("bid", row_id[i], bid);
         check_resp("bresp", row_resp[i], axi_resp_e'(bresp));
      end else begin
         check_flag("rvalid", 1'b1, rvalid);
         check_id("rid", row_id[i], rid);
         check_resp("rresp", row_resp[i], axi_resp_e'(rresp));
         check_data("rdata", row_rdata[i], rdata);
         check_flag("rlast", 1'b1, rlast);
      end
   endtask

   initial begin : watchdog
      repeat (NUM_ROWS * 40) @(posedge clk);
      $display("Timeout: responses still missing after %0d clock cycles", NUM_ROWS * 40);
      stop_run();
   end

   initial begin : main
      int r;
      int k;
      int n_sent;
      int order [$];
      reset          = 1'b1;
      awvalid        = 1'b0;
      awid           = '0;
      awaddr         = '0;
      awsize         = '0;
      wvalid         = 1'b0;
      wdata          = '0;
      wstrb          = '0;
      bready         = 1'b1;
      arvalid        = 1'b0;
      arid           = '0;
      araddr         = '0;
      arsize         = '0;
      rready         = 1'b1;
      dccm_ready     = 1'b1;
      iccm_ready     = 1'b1;
      dccm_rvalid    = 1'b0;
      dccm_rtag      = '0;
      dccm_ecc_error = 1'b0;
      dccm_rdata     = '0;
      iccm_rvalid    = 1'b0;
      iccm_rtag      = '0;
      iccm_ecc_error = 1'b0;
      iccm_rdata     = '0;
      init_memories();
      build_table();
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(posedge clk);                          // Idle state after reset
      check_flag("awready", 1'b1, awready);
      check_flag("wready", 1'b1, wready);
      check_flag("arready", 1'b1, arready);
      check_flag("bvalid", 1'b0, bvalid);
      check_flag("rvalid", 1'b0, rvalid);
      check_flag("dma_dccm_req", 1'b0, dma_dccm_req);
      check_flag("dma_iccm_req", 1'b0, dma_iccm_req);
      check_flag("dma_active", 1'b0, dma_active);
      r      = 0;
      n_sent = 0;
      while (r < NUM_ROWS) begin
         if (!row_bp[r]) begin
            present_cmds(row_write[r], r, !row_write[r], r);
            collect_resp(r);
            n_sent++;
            r++;
         end else begin
            @(negedge clk);
            bready = 1'b0;
            rready = 1'b0;
            order.delete();
            k = r;
            while (k < NUM_ROWS && row_bp[k]) begin
               present_cmds(1'b1, k, 1'b1, k + 1);
               // Priority starts at read and flips on every command sent
               if (n_sent % 2 == 0) begin
                  order.push_back(k + 1);
                  order.push_back(k);
               end else begin
                  order.push_back(k);
                  order.push_back(k + 1);
               end
               n_sent += 2;
               k += 2;
            end
            repeat (3) @(posedge clk);
            check_flag("awready", 1'b0, awready);   // Buffer and holding registers full
            check_flag("wready", 1'b0, wready);
            check_flag("arready", 1'b0, arready);
            check_flag("dma_active", 1'b1, dma_active);
            @(negedge clk);
            bready = 1'b1;
            rready = 1'b1;
            for (int i = 0; i < order.size(); i++) collect_resp(order[i]);
            r = k;
         end
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule
